// File: Bender.yml
package:
  name: kicker_monitor

sources:
  - design/kicker_pkg.sv
  - design/i2c_adc_reader.sv
  - design/charge_supervisor.sv
  - design/kicker_monitor.sv
  - target: test
    files:
      - tests/adc_slave_model.sv
      - tests/kicker_monitor_assertions.sv
      - tests/kicker_monitor_tb.sv

// File: design/charge_supervisor.sv
/* combines capacitor and battery samples into
   charge enable, kick ready and fault levels. */
module charge_supervisor
	import kicker_pkg::*;
#(
	parameter sample_t cap_target  = default_cap_target,
	parameter sample_t battery_min = default_battery_min
) (
	input  logic    sysclk,
	input  logic    arst_n,
	input  logic    cap_valid,
	input  logic    cap_ok,
	input  sample_t cap_value,
	input  logic    bat_valid,
	input  logic    bat_ok,
	input  sample_t bat_value,
	output logic    charge_enable,
	output logic    kick_ready,
	output logic    fault
);

	sample_t cap_held;
	sample_t bat_held;
	logic    cap_ok_q;
	logic    bat_ok_q;
	logic    cap_seen;
	logic    bat_seen;
	logic    fault_next;
	logic    cap_charged;

	// latest readings, refused transactions leave the value as is.
	always_ff @(posedge sysclk) begin
		if (cap_valid) begin
			cap_held <= cap_value;
		end
		if (bat_valid) begin
			bat_held <= bat_value;
		end
	end

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			cap_ok_q <= 1'b0;
			bat_ok_q <= 1'b0;
			cap_seen <= 1'b0;
			bat_seen <= 1'b0;
		end else begin
			if (cap_valid) begin
				cap_ok_q <= cap_ok;
				cap_seen <= cap_seen | cap_ok;   // sticky after first good one.
			end
			if (bat_valid) begin
				bat_ok_q <= bat_ok;
				bat_seen <= bat_seen | bat_ok;
			end
		end
	end

	assign fault_next = !cap_seen || !bat_seen || !cap_ok_q || !bat_ok_q
		|| (bat_held < battery_min);
	assign cap_charged = (cap_held >= cap_target);

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			fault         <= 1'b1;   // no data yet.
			charge_enable <= 1'b0;
			kick_ready    <= 1'b0;
		end else begin
			fault         <= fault_next;
			charge_enable <= !fault_next && !cap_charged;
			kick_ready    <= !fault_next && cap_charged;
		end
	end

endmodule

// File: design/i2c_adc_reader.sv
/* bit-banged i2c master polling one voltage adc,
   reports bits 11 to 4 of each conversion with a one-cycle strobe. */
module i2c_adc_reader
	import kicker_pkg::*;
#(
	parameter int         scl_period     = default_scl_period,
	parameter logic [7:0] device_address = default_cap_address
) (
	input  logic    sysclk,
	input  logic    arst_n,
	output logic    scl_out,
	output logic    sda_out,   // 1 releases the line.
	input  logic    sda_in,
	output logic    slave_ok,
	output logic    sample_valid,
	output sample_t sample
);

	localparam int div_w = $clog2(scl_period);

	// timing points within one scl period.
	localparam logic [div_w-1:0] div_last  = div_w'(scl_period - 1);
	localparam logic [div_w-1:0] div_start = div_w'(scl_period / 4);
	localparam logic [div_w-1:0] div_fall  = div_w'(scl_period / 2);
	localparam logic [div_w-1:0] div_setup = div_w'(scl_period * 3 / 4);

	logic [div_w-1:0] clk_div;
	reader_state_e    state;
	logic [2:0]       bit_count;
	logic             sda_in_s;
	logic [15:0]      word;
	logic             mid_high;
	logic             setup_point;

	// mid_high doubles as the start and stop edge and the sda sample point.
	assign mid_high    = (clk_div == div_start);
	assign setup_point = (clk_div == div_setup);

	// free-running scl divider.
	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			clk_div <= '0;
			scl_out <= 1'b1;
		end else begin
			if (clk_div == div_last) begin
				clk_div <= '0;
			end else begin
				clk_div <= clk_div + 1'b1;
			end

			if (clk_div == '0) begin
				scl_out <= 1'b1;
			end else if (clk_div == div_fall) begin
				scl_out <= 1'b0;
			end
		end
	end

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			sda_in_s <= 1'b1;   // idle bus reads high.
		end else begin
			sda_in_s <= sda_in;
		end
	end

	// conversion word, msb first across both data bytes.
	always_ff @(posedge sysclk) begin
		if (mid_high && (state == st_data_high || state == st_data_low)) begin
			word <= {word[14:0], sda_in_s};
		end
	end

	always_ff @(posedge sysclk or negedge arst_n) begin
		if (!arst_n) begin
			state        <= st_start;
			bit_count    <= '0;
			sda_out      <= 1'b1;
			slave_ok     <= 1'b0;
			sample_valid <= 1'b0;
			sample       <= '0;
		end else begin
			sample_valid <= 1'b0;
			case (state)
				st_start: begin
					if (clk_div == '0) begin
						sda_out <= 1'b1;
					end else if (mid_high) begin
						sda_out <= 1'b0;   // falls while scl is high.
					end else if (setup_point) begin
						sda_out   <= device_address[7];
						bit_count <= '0;
						state     <= st_address;
					end
				end

				st_address: begin
					if (setup_point) begin
						if (bit_count == 3'd7) begin
							sda_out <= 1'b1;   // let the adc acknowledge.
							state   <= st_slave_ack;
						end else begin
							sda_out <= device_address[3'd6 - bit_count];
						end
						bit_count <= bit_count + 1'b1;
					end
				end

				st_slave_ack: begin
					if (mid_high) begin
						slave_ok <= ~sda_in_s;
					end else if (setup_point) begin
						bit_count <= '0;
						if (slave_ok) begin
							state <= st_data_high;
						end else begin
							// refused, report and retry.
							sample_valid <= 1'b1;
							state        <= st_start;
						end
					end
				end

				st_data_high: begin
					if (setup_point) begin
						if (bit_count == 3'd7) begin
							sda_out <= 1'b0;   // master ack.
							state   <= st_master_ack;
						end
						bit_count <= bit_count + 1'b1;
					end
				end

				st_master_ack: begin
					if (setup_point) begin
						sda_out   <= 1'b1;
						bit_count <= '0;
						state     <= st_data_low;
					end
				end

				st_data_low: begin
					if (setup_point) begin
						if (bit_count == 3'd7) begin
							state <= st_master_nack;
						end
						bit_count <= bit_count + 1'b1;
					end
				end

				st_master_nack: begin
					if (setup_point) begin
						sample       <= word[11:4];
						sample_valid <= 1'b1;
						sda_out      <= 1'b0;   // low first so stop can rise.
						state        <= st_stop;
					end
				end

				st_stop: begin
					if (mid_high) begin
						sda_out <= 1'b1;   // rises while scl is high.
					end else if (setup_point) begin
						state <= st_start;
					end
				end

				default: begin
					state <= st_start;
				end
			endcase
		end
	end

endmodule

// File: design/kicker_monitor.sv
/* kicker monitor top, two adc readers on separate buses
   feeding the charge supervisor. */
module kicker_monitor
	import kicker_pkg::*;
#(
	parameter int         scl_period      = default_scl_period,
	parameter logic [7:0] cap_address     = default_cap_address,
	parameter logic [7:0] battery_address = default_battery_address,
	parameter sample_t    cap_target      = default_cap_target,
	parameter sample_t    battery_min     = default_battery_min
) (
	input  logic    sysclk,
	input  logic    arst_n,
	output logic    cap_scl,
	output logic    cap_sda_out,
	input  logic    cap_sda_in,
	output logic    bat_scl,
	output logic    bat_sda_out,
	input  logic    bat_sda_in,
	output sample_t cap_sample,
	output sample_t bat_sample,
	output logic    charge_enable,
	output logic    kick_ready,
	output logic    fault
);

	logic cap_valid;
	logic cap_ok;
	logic bat_valid;
	logic bat_ok;

	i2c_adc_reader #(
		.scl_period    (scl_period),
		.device_address(cap_address)
	) cap_reader_i (
		.sysclk      (sysclk),
		.arst_n      (arst_n),
		.scl_out     (cap_scl),
		.sda_out     (cap_sda_out),
		.sda_in      (cap_sda_in),
		.slave_ok    (cap_ok),
		.sample_valid(cap_valid),
		.sample      (cap_sample)
	);

	i2c_adc_reader #(
		.scl_period    (scl_period),
		.device_address(battery_address)
	) bat_reader_i (
		.sysclk      (sysclk),
		.arst_n      (arst_n),
		.scl_out     (bat_scl),
		.sda_out     (bat_sda_out),
		.sda_in      (bat_sda_in),
		.slave_ok    (bat_ok),
		.sample_valid(bat_valid),
		.sample      (bat_sample)
	);

	charge_supervisor #(
		.cap_target (cap_target),
		.battery_min(battery_min)
	) supervisor_i (
		.sysclk       (sysclk),
		.arst_n       (arst_n),
		.cap_valid    (cap_valid),
		.cap_ok       (cap_ok),
		.cap_value    (cap_sample),
		.bat_valid    (bat_valid),
		.bat_ok       (bat_ok),
		.bat_value    (bat_sample),
		.charge_enable(charge_enable),
		.kick_ready   (kick_ready),
		.fault        (fault)
	);

endmodule

// File: design/kicker_pkg.sv
/* shared sample and reader state types,
   default bus timing, adc addresses and supervisor thresholds. */
package kicker_pkg;

	// one adc reading, bits 11 to 4 of the conversion word.
	typedef logic [7:0] sample_t;

	// reader phases, one or more scl periods each.
	typedef enum logic [2:0] {
		st_start,        // start condition.
		st_address,      // address and read bit, msb first.
		st_slave_ack,    // sda released for the adc.
		st_data_high,
		st_master_ack,
		st_data_low,
		st_master_nack,  // sda released, last byte done.
		st_stop
	} reader_state_e;

	// sysclk cycles per scl period, at least 16.
	localparam int default_scl_period = 46;

	// address plus read bit for each adc.
	localparam logic [7:0] default_cap_address     = 8'ha1;
	localparam logic [7:0] default_battery_address = 8'ha3;

	// capacitor counts as charged at or above this.
	localparam sample_t default_cap_target = 8'hb4;

	// battery below this is a fault.
	localparam sample_t default_battery_min = 8'h80;

endpackage

// File: tests/adc_slave_model.sv
/* behavioral i2c adc slave, decodes the address byte,
   acks or refuses, serves one 16-bit word per transaction. */
module adc_slave_model (
	input  logic        scl,
	input  logic        sda,          // resolved bus level.
	input  logic [7:0]  expected_address,
	input  logic [15:0] word,
	input  logic        ack_en,
	output logic        sda_drive,    // 1 releases the line.
	output int          txn_count,
	output logic        addr_error,
	output logic        ack_error
);
	timeunit 1ns;
	timeprecision 100ps;

	int          n;          // scl rises since start.
	logic        active;
	logic        refused;
	logic [7:0]  shift;
	logic [15:0] word_q;

	initial begin
		sda_drive  = 1'b1;
		txn_count  = 0;
		addr_error = 1'b0;
		ack_error  = 1'b0;
		active     = 1'b0;
		refused    = 1'b0;
		n          = 0;
	end

	// start condition.
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			active    = 1'b1;
			n         = 0;
			sda_drive = 1'b1;
		end
	end

	// stop condition closes an acknowledged transaction.
	always @(posedge sda) begin
		if (scl === 1'b1 && active) begin
			active = 1'b0;
			txn_count++;
		end
	end

	always @(posedge scl) begin
		if (active) begin
			n++;
			if (n <= 8) begin
				shift = {shift[6:0], sda};
			end else if (n == 9 && refused) begin
				active = 1'b0;   // master retries with a new start.
				txn_count++;
			end else if (n == 18 && sda !== 1'b0) begin
				ack_error = 1'b1;   // master ack missing.
			end else if (n == 27 && sda !== 1'b1) begin
				ack_error = 1'b1;   // final nack missing.
			end
		end
	end

	always @(negedge scl) begin
		if (active) begin
			if (n == 8) begin
				if (shift != expected_address) begin
					addr_error = 1'b1;
				end
				refused   = !ack_en || (shift != expected_address);
				word_q    = word;
				sda_drive = refused;
			end else if (n >= 9 && n <= 16) begin
				sda_drive = word_q[24-n];   // high byte.
			end else if (n >= 18 && n <= 25) begin
				sda_drive = word_q[25-n];   // low byte.
			end else begin
				sda_drive = 1'b1;
			end
		end
	end

endmodule

// File: tests/kicker_monitor_assertions.sv
/* bus protocol and output assertions for the kicker monitor. */
module kicker_monitor_assertions
	import kicker_pkg::*;
(
	input logic          sysclk,
	input logic          arst_n,
	input logic          cap_valid,
	input logic          bat_valid,
	input logic          cap_scl,
	input logic          cap_sda_out,
	input logic          bat_scl,
	input logic          bat_sda_out,
	input reader_state_e cap_state,
	input reader_state_e bat_state,
	input logic          charge_enable,
	input logic          kick_ready,
	input logic          fault
);
	timeunit 1ns;
	timeprecision 100ps;

	cap_valid_pulse: assert property (@(posedge sysclk) disable iff (!arst_n)
		cap_valid |=> !cap_valid) else $error("cap sample strobe held for two cycles");
	bat_valid_pulse: assert property (@(posedge sysclk) disable iff (!arst_n)
		bat_valid |=> !bat_valid) else $error("battery sample strobe held for two cycles");

	// sda moves under high scl only for start and stop.
	cap_sda_stable: assert property (@(posedge sysclk) disable iff (!arst_n)
		$changed(cap_sda_out) && $past(cap_scl) |-> $past(cap_state) inside {st_start, st_stop})
		else $error("cap bus sda changed while scl high");
	bat_sda_stable: assert property (@(posedge sysclk) disable iff (!arst_n)
		$changed(bat_sda_out) && $past(bat_scl) |-> $past(bat_state) inside {st_start, st_stop})
		else $error("battery bus sda changed while scl high");

	// levels move only two cycles after a sample strobe.
	levels_follow_strobe: assert property (@(posedge sysclk) disable iff (!arst_n)
		$changed({charge_enable, kick_ready, fault}) |-> $past(cap_valid || bat_valid, 2))
		else $error("supervisor level changed without a sample strobe");

endmodule

bind kicker_monitor kicker_monitor_assertions assertions_i (
	.sysclk       (sysclk),
	.arst_n       (arst_n),
	.cap_valid    (cap_valid),
	.bat_valid    (bat_valid),
	.cap_scl      (cap_scl),
	.cap_sda_out  (cap_sda_out),
	.bat_scl      (bat_scl),
	.bat_sda_out  (bat_sda_out),
	.cap_state    (cap_reader_i.state),
	.bat_state    (bat_reader_i.state),
	.charge_enable(charge_enable),
	.kick_ready   (kick_ready),
	.fault        (fault)
);

// File: tests/kicker_monitor_tb.sv
/* kicker monitor testbench, two adc models on open-drain buses,
   random words from an lcg and a reference model of the supervisor. */
module kicker_monitor_tb
	import kicker_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_txn          = 24;
	localparam int timeout_cycles = 2 * n_txn * 28 * 16 * 5 / 4;

	logic        sysclk;
	logic        arst_n;
	logic        cap_scl;
	logic        cap_sda_out;
	logic        bat_scl;
	logic        bat_sda_out;
	logic        cap_drive;
	logic        bat_drive;
	wire         cap_sda = cap_sda_out & cap_drive;   // open-drain bus.
	wire         bat_sda = bat_sda_out & bat_drive;
	sample_t     cap_sample;
	sample_t     bat_sample;
	logic        charge_enable;
	logic        kick_ready;
	logic        fault;
	int          cap_count;
	int          bat_count;
	logic        cap_addr_err;
	logic        cap_ack_err;
	logic        bat_addr_err;
	logic        bat_ack_err;
	logic [15:0] cap_words [64];
	logic        cap_acks [64];
	logic [15:0] bat_words [64];
	logic        bat_acks [64];
	logic [31:0] rng_state;
	sample_t     cap_held;
	sample_t     bat_held;
	logic        cap_ok_m;
	logic        bat_ok_m;
	logic        cap_seen_m;
	logic        bat_seen_m;
	logic [2:0]  exp_d1;   // {charge_enable, kick_ready, fault}.
	logic [2:0]  exp_d2;
	int          cap_idx;
	int          bat_idx;
	int          cycles;
	int          error_count;

	kicker_monitor #(.scl_period(16)) kicker_monitor_i (
		.sysclk       (sysclk),
		.arst_n       (arst_n),
		.cap_scl      (cap_scl),
		.cap_sda_out  (cap_sda_out),
		.cap_sda_in   (cap_sda),
		.bat_scl      (bat_scl),
		.bat_sda_out  (bat_sda_out),
		.bat_sda_in   (bat_sda),
		.cap_sample   (cap_sample),
		.bat_sample   (bat_sample),
		.charge_enable(charge_enable),
		.kick_ready   (kick_ready),
		.fault        (fault)
	);

	adc_slave_model cap_adc_i (
		.scl(cap_scl), .sda(cap_sda), .expected_address(default_cap_address),
		.word(cap_words[cap_count % 64]), .ack_en(cap_acks[cap_count % 64]),
		.sda_drive(cap_drive), .txn_count(cap_count),
		.addr_error(cap_addr_err), .ack_error(cap_ack_err)
	);

	adc_slave_model bat_adc_i (
		.scl(bat_scl), .sda(bat_sda), .expected_address(default_battery_address),
		.word(bat_words[bat_count % 64]), .ack_en(bat_acks[bat_count % 64]),
		.sda_drive(bat_drive), .txn_count(bat_count),
		.addr_error(bat_addr_err), .ack_error(bat_ack_err)
	);

	always #2 sysclk = ~sysclk;

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// reference supervisor rule on the held values.
	function automatic logic [2:0] supervisor_rule();
		logic f;
		f = !cap_seen_m || !bat_seen_m || !cap_ok_m || !bat_ok_m
			|| (bat_held < default_battery_min);
		return {!f && (cap_held < default_cap_target),
			!f && (cap_held >= default_cap_target), f};
	endfunction

	task automatic stop_with(string what);
		error_count++;
		$display("error at %0d ns: %s", $time, what);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_sample(sample_t actual, sample_t expected, string what);
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_level(bit actual, bit expected, string what);
		if (actual !== expected) begin
			error_count++;
			$display("mismatch at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1, "stopped at first error");
		end
	endtask

	always @(negedge sysclk) begin
		if (arst_n) begin
			if (cap_addr_err || bat_addr_err) begin
				stop_with("an adc model decoded a wrong address byte");
			end
			if (cap_ack_err || bat_ack_err) begin
				stop_with("master ack or nack came at the wrong bit");
			end
			check_level(charge_enable, exp_d2[2], "charge_enable");
			check_level(kick_ready, exp_d2[1], "kick_ready");
			check_level(fault, exp_d2[0], "fault");
			exp_d2 = exp_d1;
			if (kicker_monitor_i.cap_valid) begin
				if (cap_acks[cap_idx % 64]) begin
					cap_held   = cap_words[cap_idx % 64][11:4];
					cap_seen_m = 1'b1;
				end
				cap_ok_m = cap_acks[cap_idx % 64];
				check_sample(cap_sample, cap_held, "cap_sample");   // refused keeps old value.
				cap_idx++;
			end
			if (kicker_monitor_i.bat_valid) begin
				if (bat_acks[bat_idx % 64]) begin
					bat_held   = bat_words[bat_idx % 64][11:4];
					bat_seen_m = 1'b1;
				end
				bat_ok_m = bat_acks[bat_idx % 64];
				check_sample(bat_sample, bat_held, "bat_sample");
				bat_idx++;
			end
			exp_d1 = supervisor_rule();
		end
	end

	initial begin
		logic [31:0] r;
		sysclk      = 1'b0;
		arst_n      = 1'b0;
		rng_state   = 32'h50b9;
		cap_held    = '0;
		bat_held    = '0;
		cap_ok_m    = 1'b0;
		bat_ok_m    = 1'b0;
		cap_seen_m  = 1'b0;
		bat_seen_m  = 1'b0;
		exp_d1      = 3'b001;
		exp_d2      = 3'b001;
		cap_idx     = 0;
		bat_idx     = 0;
		cycles      = 0;
		error_count = 0;
		for (int i = 0; i < 64; i++) begin
			r = lcg_next();
			cap_words[i] = r[23:8];
			r = lcg_next();
			cap_acks[i] = (r[20:18] != 3'd0);   // about one in eight refused.
			r = lcg_next();
			bat_words[i] = r[23:8];
			r = lcg_next();
			bat_acks[i] = (r[20:18] != 3'd0);
		end
		repeat (2) @(negedge sysclk);
		check_level(cap_scl & bat_scl, 1'b1, "scl after reset");
		check_level(cap_sda & bat_sda, 1'b1, "sda after reset");
		check_sample(cap_sample, '0, "cap_sample after reset");
		check_sample(bat_sample, '0, "bat_sample after reset");
		check_level(charge_enable | kick_ready, 1'b0, "charge or ready after reset");
		check_level(fault, 1'b1, "fault after reset");
		arst_n = 1'b1;
		while (cap_idx < n_txn || bat_idx < n_txn) begin
			@(negedge sysclk);
			cycles++;
			if (cycles > timeout_cycles) begin
				stop_with("timeout, readers stopped reporting samples");
			end
		end
		// levels of the last samples land two cycles later.
		repeat (3) @(negedge sysclk);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verilog.f
design/kicker_pkg.sv
design/i2c_adc_reader.sv
design/charge_supervisor.sv
design/kicker_monitor.sv
tests/adc_slave_model.sv
tests/kicker_monitor_assertions.sv
tests/kicker_monitor_tb.sv
